// ==== verilog/mips_pkg.sv ====
package mips_pkg;

    localparam int isa_width           = 32;
    localparam int shift_amount_width  = 5;
    localparam int reg_file_addr_width = 5;
    localparam int address_width       = 26;   // j / jal target field

    typedef logic [isa_width - 1:0]           word_t;
    typedef logic [reg_file_addr_width - 1:0] reg_idx_t;

    localparam reg_idx_t jal_reg_idx = 5'd31;  // link register

    typedef enum logic [5:0] {
        op_special = 6'd0,                     // r type, decoded further by funct
        op_j       = 6'd2,
        op_jal     = 6'd3,
        op_beq     = 6'd4,
        op_bne     = 6'd5,
        op_blez    = 6'd6,
        op_bgtz    = 6'd7,
        op_addi    = 6'd8,
        op_addiu   = 6'd9,
        op_slti    = 6'd10,
        op_andi    = 6'd12,
        op_ori     = 6'd13,
        op_xori    = 6'd14,
        op_lui     = 6'd15,
        op_lw      = 6'd35,
        op_sw      = 6'd43
    } opcode_e;

    typedef enum logic [5:0] {
        fn_sll  = 6'd0,
        fn_srl  = 6'd2,
        fn_sra  = 6'd3,
        fn_jr   = 6'd8,
        fn_add  = 6'd32,
        fn_addu = 6'd33,
        fn_sub  = 6'd34,
        fn_subu = 6'd35,
        fn_and  = 6'd36,
        fn_or   = 6'd37,
        fn_xor  = 6'd38,
        fn_nor  = 6'd39,
        fn_slt  = 6'd42
    } funct_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_nor,
        alu_slt, alu_sll, alu_srl, alu_sra, alu_lui
    } alu_op_e;

endpackage

// ==== verilog/operand_if.sv ====
interface operand_if;
    import mips_pkg::*;

    word_t    mux_operand_1;                   // alu operand a
    word_t    mux_operand_2;                   // alu operand b, also the branch offset
    reg_idx_t mux_reg_1_idx;                   // zero when rs is not read
    reg_idx_t mux_reg_2_idx;                   // zero when rt is not read
    reg_idx_t mux_reg_dest_idx;                // zero when nothing is written back
    word_t    store_data;                      // rt value for sw

    modport producer (
        output mux_operand_1, mux_operand_2, mux_reg_1_idx, mux_reg_2_idx,
        output mux_reg_dest_idx, store_data
    );

    modport consumer (
        input mux_operand_1, mux_operand_2, mux_reg_1_idx, mux_reg_2_idx,
        input mux_reg_dest_idx, store_data
    );

endinterface

// ==== verilog/if_id_reg.sv ====
module if_id_reg (
    input  logic            clk,
    input  logic            reset,
    input  logic            in_valid,          // fetch presents an instruction
    input  mips_pkg::word_t in_instruction,
    input  mips_pkg::word_t in_pc,
    input  logic            stall,             // from id_ex_reg, hold everything
    input  logic            flush,             // redirect this cycle, squash the slot behind it
    output mips_pkg::word_t id_instruction,
    output mips_pkg::word_t id_pc,
    output logic            id_no_op           // slot holds a gap
);

    // control bit: a gap after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            id_no_op <= 1'b1;
        end else if (!stall) begin
            id_no_op <= ~in_valid | flush;     // nothing fetched or wrong path
        end
    end

    // payload follows the same hold rule
    always_ff @(posedge clk) begin
        if (!stall) begin
            id_instruction <= in_instruction;
            id_pc          <= in_pc;
        end
    end

endmodule

// ==== verilog/control_unit.sv ====
module control_unit (
    input  mips_pkg::word_t   id_instruction,
    output logic              i_type_instruction,   // operand 2 is the immediate
    output logic              r_type_instruction,   // reads rs and rt, writes rd
    output logic              j_instruction,
    output logic              jr_instruction,
    output logic              jal_instruction,
    output logic              branch_instruction,
    output logic              store_instruction,
    output logic              shift_instruction,    // operand 1 is the shamt field
    output logic              load_instruction,
    output mips_pkg::alu_op_e alu_op,
    output mips_pkg::word_t   id_sign_extend_result
);
    import mips_pkg::*;

    opcode_e     opcode;
    funct_e      funct;
    logic [15:0] imm;

    assign opcode = opcode_e'(id_instruction[31:26]);
    assign funct  = funct_e'(id_instruction[5:0]);
    assign imm    = id_instruction[15:0];

    always_comb begin
        i_type_instruction = 1'b0;             // unknown encodings fall through as no-ops
        r_type_instruction = 1'b0;
        j_instruction      = 1'b0;
        jr_instruction     = 1'b0;
        jal_instruction    = 1'b0;
        branch_instruction = 1'b0;
        store_instruction  = 1'b0;
        shift_instruction  = 1'b0;
        load_instruction   = 1'b0;
        alu_op             = alu_add;
        case (opcode)
            op_special: begin
                r_type_instruction = 1'b1;
                case (funct)
                    fn_sll:           begin shift_instruction = 1'b1; alu_op = alu_sll; end
                    fn_srl:           begin shift_instruction = 1'b1; alu_op = alu_srl; end
                    fn_sra:           begin shift_instruction = 1'b1; alu_op = alu_sra; end
                    fn_add, fn_addu:  alu_op = alu_add;
                    fn_sub, fn_subu:  alu_op = alu_sub;
                    fn_and:           alu_op = alu_and;
                    fn_or:            alu_op = alu_or;
                    fn_xor:           alu_op = alu_xor;
                    fn_nor:           alu_op = alu_nor;
                    fn_slt:           alu_op = alu_slt;
                    fn_jr: begin
                        r_type_instruction = 1'b0;   // jr only reads rs
                        jr_instruction     = 1'b1;
                    end
                    default:          r_type_instruction = 1'b0;
                endcase
            end
            op_j:     j_instruction   = 1'b1;
            op_jal:   jal_instruction = 1'b1;  // alu adds pc + 4 for the link value
            op_beq, op_bne, op_blez, op_bgtz: begin
                i_type_instruction = 1'b1;     // immediate carries the offset
                branch_instruction = 1'b1;
                alu_op             = alu_sub;
            end
            op_addi, op_addiu: i_type_instruction = 1'b1;
            op_slti:  begin i_type_instruction = 1'b1; alu_op = alu_slt; end
            op_andi:  begin i_type_instruction = 1'b1; alu_op = alu_and; end
            op_ori:   begin i_type_instruction = 1'b1; alu_op = alu_or;  end
            op_xori:  begin i_type_instruction = 1'b1; alu_op = alu_xor; end
            op_lui:   begin i_type_instruction = 1'b1; alu_op = alu_lui; end
            op_lw:    begin i_type_instruction = 1'b1; load_instruction  = 1'b1; end
            op_sw:    begin i_type_instruction = 1'b1; store_instruction = 1'b1; end
            default:  ;
        endcase
    end

    always_comb begin
        case (opcode)
            op_andi, op_ori, op_xori:         id_sign_extend_result = {16'b0, imm};
            op_lui:                           id_sign_extend_result = {imm, 16'b0};
            op_beq, op_bne, op_blez, op_bgtz: id_sign_extend_result = {{14{imm[15]}}, imm, 2'b00};
            default:                          id_sign_extend_result = {{16{imm[15]}}, imm};
        endcase
    end

endmodule

// ==== verilog/general_reg.sv ====
module general_reg (
    input  logic               clk,
    input  logic               reset,
    input  logic               wb_enable,      // write-back strobe
    input  mips_pkg::reg_idx_t wb_idx,
    input  mips_pkg::word_t    wb_data,
    input  mips_pkg::reg_idx_t id_reg_1_idx,   // rs
    input  mips_pkg::reg_idx_t id_reg_2_idx,   // rt
    output mips_pkg::word_t    id_reg_1,
    output mips_pkg::word_t    id_reg_2
);
    import mips_pkg::*;

    word_t regs [2 ** reg_file_addr_width];
    logic  wb_live;                            // a write that really lands

    assign wb_live = wb_enable & (wb_idx != '0);   // $zero is read only

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2 ** reg_file_addr_width; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_live) begin
            regs[wb_idx] <= wb_data;
        end
    end

    // write-first: a same-cycle write shows up on the read port
    assign id_reg_1 = (wb_live && wb_idx == id_reg_1_idx) ? wb_data : regs[id_reg_1_idx];
    assign id_reg_2 = (wb_live && wb_idx == id_reg_2_idx) ? wb_data : regs[id_reg_2_idx];

endmodule

// ==== verilog/condition_check.sv ====
module condition_check (
    input  mips_pkg::word_t id_instruction,
    input  mips_pkg::word_t id_reg_1,          // rs
    input  mips_pkg::word_t id_reg_2,          // rt, only beq / bne look at it
    output logic            condition_satisfied
);
    import mips_pkg::*;

    opcode_e opcode;

    assign opcode = opcode_e'(id_instruction[31:26]);

    always_comb begin
        case (opcode)
            op_beq:  condition_satisfied = (id_reg_1 == id_reg_2);
            op_bne:  condition_satisfied = (id_reg_1 != id_reg_2);
            op_blez: condition_satisfied = ($signed(id_reg_1) <= 0);   // signed compare
            op_bgtz: condition_satisfied = ($signed(id_reg_1) > 0);
            default: condition_satisfied = 1'b0;
        endcase
    end

endmodule

// ==== verilog/signal_mux.sv ====
module signal_mux (
    input  logic               i_type_instruction,   // from control_unit
    input  logic               r_type_instruction,
    input  logic               j_instruction,
    input  logic               jr_instruction,
    input  logic               jal_instruction,
    input  logic               branch_instruction,
    input  logic               store_instruction,
    input  logic               shift_instruction,
    input  logic               condition_satisfied,  // from condition_check
    input  logic               id_no_op,             // from if_id_reg
    input  logic               stall,                // from id_ex_reg
    output logic               pc_offset,            // taken branch
    output logic               pc_overload,          // j, jal, jr
    input  mips_pkg::word_t    id_reg_1,
    input  mips_pkg::word_t    id_pc,
    input  logic [mips_pkg::shift_amount_width - 1:0] shift_amount,
    input  mips_pkg::word_t    id_reg_2,
    input  mips_pkg::word_t    id_sign_extend_result,
    input  mips_pkg::word_t    id_instruction,
    output mips_pkg::word_t    pc_overload_value,
    input  mips_pkg::reg_idx_t id_reg_1_idx,         // rs field
    input  mips_pkg::reg_idx_t id_reg_2_idx,         // rt field
    input  mips_pkg::reg_idx_t id_reg_dest_idx,      // rd field
    operand_if.producer        ops
);
    import mips_pkg::*;

    logic j_type_normal;                       // j or jal, absolute target
    logic advancing;                           // a real instruction leaves this cycle
    logic reg_1_valid;                         // rs is really read
    logic reg_2_valid;                         // rt is really read

    assign j_type_normal = j_instruction | jal_instruction;
    assign advancing     = ~id_no_op & ~stall;

    assign reg_1_valid = ~(j_type_normal | shift_instruction);
    assign reg_2_valid = r_type_instruction | branch_instruction | store_instruction;

    // redirects last exactly one cycle since the slot moves on right after
    assign pc_offset   = condition_satisfied & branch_instruction & advancing;
    assign pc_overload = (j_type_normal | jr_instruction) & advancing;

    assign pc_overload_value = j_type_normal ? {
                                   id_pc[isa_width - 1:address_width + 2],
                                   id_instruction[address_width - 1:0],
                                   2'b00
                               } : id_reg_1;   // jr jumps to rs

    assign ops.mux_operand_1 = jal_instruction   ? id_pc :
                               shift_instruction ? word_t'(shift_amount) : id_reg_1;
    assign ops.mux_operand_2 = i_type_instruction ? id_sign_extend_result :
                               jal_instruction    ? word_t'(4) : id_reg_2;

    assign ops.mux_reg_1_idx = reg_1_valid ? id_reg_1_idx : '0;
    assign ops.mux_reg_2_idx = reg_2_valid ? id_reg_2_idx : '0;
    assign ops.store_data    = id_reg_2;

    always_comb begin
        if (store_instruction | branch_instruction | jr_instruction) begin
            ops.mux_reg_dest_idx = '0;             // no write-back
        end else if (jal_instruction) begin
            ops.mux_reg_dest_idx = jal_reg_idx;    // link in $ra
        end else if (i_type_instruction) begin
            ops.mux_reg_dest_idx = id_reg_2_idx;   // rt
        end else begin
            ops.mux_reg_dest_idx = id_reg_dest_idx;
        end
    end

endmodule

// ==== verilog/id_ex_reg.sv ====
module id_ex_reg #(
    parameter int credits = 4                  // execute side slots, 1 to 15
) (
    input  logic               clk,
    input  logic               reset,
    operand_if.consumer        ops,
    input  mips_pkg::alu_op_e  alu_op,
    input  logic               load_instruction,
    input  logic               store_instruction,
    input  logic               id_no_op,
    input  logic               credit_return,  // one pulse per freed slot
    output logic               stall,
    output logic               out_valid,
    output mips_pkg::word_t    out_operand_1,
    output mips_pkg::word_t    out_operand_2,
    output mips_pkg::word_t    out_store_data,
    output mips_pkg::reg_idx_t out_reg_1_idx,
    output mips_pkg::reg_idx_t out_reg_2_idx,
    output mips_pkg::reg_idx_t out_dest_idx,
    output mips_pkg::alu_op_e  out_alu_op,
    output logic               out_mem_read,
    output logic               out_mem_write
);

    localparam int count_width = $clog2(credits + 1);

    logic [count_width - 1:0] credit_count;    // slots still free downstream
    logic                     advance;         // bundle loads at this edge

    assign advance = ~id_no_op & (credit_count != '0);
    assign stall   = ~id_no_op & (credit_count == '0);

    // the credit goes with the edge that raises out_valid
    always_ff @(posedge clk) begin
        if (reset) begin
            credit_count <= count_width'(credits);
            out_valid    <= 1'b0;
        end else begin
            credit_count <= credit_count - count_width'(advance) + count_width'(credit_return);
            out_valid    <= advance;           // gaps and stalls leave a bubble
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            out_operand_1  <= ops.mux_operand_1;
            out_operand_2  <= ops.mux_operand_2;
            out_store_data <= ops.store_data;
            out_reg_1_idx  <= ops.mux_reg_1_idx;
            out_reg_2_idx  <= ops.mux_reg_2_idx;
            out_dest_idx   <= ops.mux_reg_dest_idx;
            out_alu_op     <= alu_op;
            out_mem_read   <= load_instruction;
            out_mem_write  <= store_instruction;
        end
    end

endmodule

// ==== verilog/decode_stage.sv ====
module decode_stage #(
    parameter int credits = 4
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               in_valid,           // fetch side
    input  mips_pkg::word_t    in_instruction,
    input  mips_pkg::word_t    in_pc,
    output logic               stall,
    output logic               out_valid,          // execute side
    output mips_pkg::word_t    out_operand_1,
    output mips_pkg::word_t    out_operand_2,
    output mips_pkg::word_t    out_store_data,
    output mips_pkg::reg_idx_t out_reg_1_idx,
    output mips_pkg::reg_idx_t out_reg_2_idx,
    output mips_pkg::reg_idx_t out_dest_idx,
    output mips_pkg::alu_op_e  out_alu_op,
    output logic               out_mem_read,
    output logic               out_mem_write,
    input  logic               credit_return,
    output logic               pc_offset,          // instruction memory side
    output logic               pc_overload,
    output mips_pkg::word_t    pc_overload_value,
    output mips_pkg::word_t    pc_offset_value,
    input  logic               wb_enable,          // write-back port
    input  mips_pkg::reg_idx_t wb_idx,
    input  mips_pkg::word_t    wb_data
);
    import mips_pkg::*;

    word_t   id_instruction, id_pc, id_reg_1, id_reg_2, id_sign_extend_result;
    logic    id_no_op, condition_satisfied;
    logic    i_type, r_type, j_instr, jr_instr, jal_instr, branch_instr;
    logic    store_instr, shift_instr, load_instr;
    alu_op_e alu_op;

    operand_if ops ();

    assign pc_offset_value = ops.mux_operand_2;     // offset rides on operand 2

    if_id_reg u_if_id_reg (
        .clk, .reset, .in_valid, .in_instruction, .in_pc, .stall,
        .flush(pc_offset | pc_overload), .id_instruction, .id_pc, .id_no_op
    );

    control_unit u_control_unit (
        .id_instruction, .i_type_instruction(i_type), .r_type_instruction(r_type),
        .j_instruction(j_instr), .jr_instruction(jr_instr), .jal_instruction(jal_instr),
        .branch_instruction(branch_instr), .store_instruction(store_instr),
        .shift_instruction(shift_instr), .load_instruction(load_instr),
        .alu_op, .id_sign_extend_result
    );

    general_reg u_general_reg (
        .clk, .reset, .wb_enable, .wb_idx, .wb_data,
        .id_reg_1_idx(id_instruction[25:21]), .id_reg_2_idx(id_instruction[20:16]),
        .id_reg_1, .id_reg_2
    );

    condition_check u_condition_check (
        .id_instruction, .id_reg_1, .id_reg_2, .condition_satisfied
    );

    signal_mux u_signal_mux (
        .i_type_instruction(i_type), .r_type_instruction(r_type),
        .j_instruction(j_instr), .jr_instruction(jr_instr), .jal_instruction(jal_instr),
        .branch_instruction(branch_instr), .store_instruction(store_instr),
        .shift_instruction(shift_instr), .condition_satisfied, .id_no_op, .stall,
        .pc_offset, .pc_overload, .id_reg_1, .id_pc,
        .shift_amount(id_instruction[10:6]), .id_reg_2, .id_sign_extend_result,
        .id_instruction, .pc_overload_value,
        .id_reg_1_idx(id_instruction[25:21]), .id_reg_2_idx(id_instruction[20:16]),
        .id_reg_dest_idx(id_instruction[15:11]), .ops(ops.producer)
    );

    id_ex_reg #(.credits(credits)) u_id_ex_reg (
        .clk, .reset, .ops(ops.consumer), .alu_op,
        .load_instruction(load_instr), .store_instruction(store_instr),
        .id_no_op, .credit_return, .stall, .out_valid,
        .out_operand_1, .out_operand_2, .out_store_data, .out_reg_1_idx,
        .out_reg_2_idx, .out_dest_idx, .out_alu_op, .out_mem_read, .out_mem_write
    );

endmodule

// ==== test/tb_clock.sv ====
module tb_clock #(
    parameter int period       = 20,           // ns
    parameter int reset_cycles = 16
) (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;                          // held for the first reset_cycles edges
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// ==== test/decode_stage_chk.sv ====
module decode_stage_chk #(
    parameter int credits = 4
) (
    input logic clk,
    input logic reset,
    input logic out_valid,
    input logic credit_return,
    input logic stall,
    input logic pc_offset,
    input logic pc_overload
);
    timeunit 1ns;
    timeprecision 1ps;

    int   spent;                               // bundles sent and not yet given back
    int   assert_failures = 0;                 // summed into the testbench's closing line
    logic slots_full;                          // modelled credit count is zero

    always_ff @(posedge clk) begin
        if (reset) begin
            spent <= 0;
        end else begin
            spent <= spent + int'(out_valid) - int'(credit_return);
        end
    end

    // a sampled out_valid is a spend the counter only adds at this edge
    assign slots_full = (spent + int'(out_valid)) >= credits;

    credit_window: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> spent < credits)
        else begin
            $error("out_valid raised with no credit left downstream");
            assert_failures++;
        end

    redirect_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(pc_offset && pc_overload))
        else begin
            $error("pc_offset and pc_overload high together");
            assert_failures++;
        end

    // stall only when every downstream slot is taken
    stall_needs_full: assert property (@(posedge clk) disable iff (reset)
        stall |-> slots_full)
        else begin
            $error("stall high while credits remain downstream");
            assert_failures++;
        end

    // with no credit the slot cannot move, so it cannot redirect yet
    redirect_not_stalled: assert property (@(posedge clk) disable iff (reset)
        slots_full |-> !(pc_offset || pc_overload))
        else begin
            $error("redirect raised while no credit was left to advance");
            assert_failures++;
        end

    quiet_after_reset: assert property (@(posedge clk)
        reset |=> !out_valid && !stall && !pc_offset && !pc_overload)
        else begin
            $error("out_valid, stall or a redirect high in the cycle after reset");
            assert_failures++;
        end

endmodule

// ==== test/decode_stage_tb.sv ====
module decode_stage_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import mips_pkg::*;

    localparam int credits      = 4;
    localparam int period       = 20;
    localparam int reset_cycles = 16;

    typedef struct {
        int       rec;                         // record number, names the test
        word_t    operand_1, operand_2, store_data;
        reg_idx_t reg_1_idx, reg_2_idx, dest_idx;
        alu_op_e  alu_op;
        logic     mem_read, mem_write;
    } bundle_t;

    typedef struct {
        int    rec;
        logic  offset;                         // 1 for a taken branch, 0 for a jump
        word_t value;
    } redirect_t;

    logic     clk, reset, in_valid, stall, credit_return, wb_enable;
    logic     out_valid, out_mem_read, out_mem_write, pc_offset, pc_overload;
    word_t    in_instruction, in_pc, wb_data, pc_overload_value, pc_offset_value;
    word_t    out_operand_1, out_operand_2, out_store_data;
    reg_idx_t wb_idx, out_reg_1_idx, out_reg_2_idx, out_dest_idx;
    alu_op_e  out_alu_op;

    bundle_t   bundle_q[$];                    // expected bundles in issue order
    redirect_t redirect_q[$];
    string     record_lines[$];
    int        value_errors = 0;
    int        protocol_errors = 0;
    int        owed_credits = 0;               // bundles seen, credit not yet returned
    bit        records_loaded = 0;

    tb_clock #(.period(period), .reset_cycles(reset_cycles)) u_clock (.clk, .reset);

    decode_stage #(.credits(credits)) UUT (.*);

    bind decode_stage decode_stage_chk #(.credits(credits)) u_chk (
        .clk, .reset, .out_valid, .credit_return, .stall, .pc_offset, .pc_overload
    );

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            value_errors++;
            $display("ERROR %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic check_idx(input string name, input reg_idx_t expected, input reg_idx_t actual);
        if (actual !== expected) begin
            value_errors++;
            $display("ERROR %s expected %0d actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_alu(input string name, input alu_op_e expected, input alu_op_e actual);
        if (actual !== expected) begin
            value_errors++;
            $display("ERROR %s expected %s actual %s (%0d)", name, expected.name(),
                     actual.name(), actual);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            value_errors++;
            $display("ERROR %s expected %b actual %b", name, expected, actual);
        end
    endtask

    task automatic load_records();
        int    fd;
        string line;
        fd = $fopen("test/decode_stage_testdata.txt", "r");
        if (fd == 0) begin
            protocol_errors++;
            $display("could not open the test data file");
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line.getc(0) != "#") record_lines.push_back(line);
        end
        $fclose(fd);
    endtask

    // returns on the edge where fetch inputs were taken
    task automatic wait_taken();
        logic held;
        do begin
            @(negedge clk);
            held = stall;
            @(posedge clk);
        end while (held);
    endtask

    task automatic run_record(input int rec, input string line);
        logic [31:0] f [12];
        bundle_t     b;
        redirect_t   r;
        int          got;
        case (line.getc(0))
            "W": begin
                got = $sscanf(line, "W %h %h", f[0], f[1]);
                in_valid  <= 1'b0;
                wb_enable <= 1'b1;             // lands on the edge after this one
                wb_idx    <= f[0][4:0];
                wb_data   <= f[1];
                wait_taken();
            end
            "I": begin
                got = $sscanf(line, "I %h %h %h %h %h %h %h %h %h %h %h %h", f[0], f[1],
                              f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11]);
                in_valid       <= 1'b1;
                in_instruction <= f[0];
                in_pc          <= f[1];
                wb_enable      <= 1'b0;
                if (f[2] == 0) begin           // gap records expect nothing downstream
                    b.rec        = rec;
                    b.operand_1  = f[3];
                    b.operand_2  = f[4];
                    b.store_data = f[5];
                    b.reg_1_idx  = f[6][4:0];
                    b.reg_2_idx  = f[7][4:0];
                    b.dest_idx   = f[8][4:0];
                    b.alu_op     = alu_op_e'(f[9][3:0]);
                    b.mem_read   = f[10][0];
                    b.mem_write  = f[11][0];
                    bundle_q.push_back(b);
                end
                wait_taken();
                got = (got == 12) ? 2 : 0;
            end
            "R": begin
                got = $sscanf(line, "R %h %h", f[0], f[1]);
                r.rec    = rec;
                r.offset = (f[0] == 1);
                r.value  = f[1];
                redirect_q.push_back(r);       // takes no cycle
            end
            default: got = 0;
        endcase
        if (got != 2) begin
            protocol_errors++;
            $display("record %0d in the test data file is malformed", rec);
        end
    endtask

    task automatic check_bundle();
        bundle_t b;
        string   name;
        if (bundle_q.size() == 0) begin
            protocol_errors++;
            $display("a bundle arrived when none was expected");
            return;
        end
        b = bundle_q.pop_front();
        name = $sformatf("record %0d", b.rec);
        check_word({name, " operand_1"}, b.operand_1, out_operand_1);
        check_word({name, " operand_2"}, b.operand_2, out_operand_2);
        check_word({name, " store_data"}, b.store_data, out_store_data);
        check_idx({name, " reg_1_idx"}, b.reg_1_idx, out_reg_1_idx);
        check_idx({name, " reg_2_idx"}, b.reg_2_idx, out_reg_2_idx);
        check_idx({name, " dest_idx"}, b.dest_idx, out_dest_idx);
        check_alu({name, " alu_op"}, b.alu_op, out_alu_op);
        check_flag({name, " mem_read"}, b.mem_read, out_mem_read);
        check_flag({name, " mem_write"}, b.mem_write, out_mem_write);
    endtask

    task automatic check_redirect();
        redirect_t r;
        string     name;
        if (redirect_q.size() == 0) begin
            protocol_errors++;
            $display("a redirect was raised when none was expected");
            return;
        end
        r = redirect_q.pop_front();
        name = $sformatf("record %0d", r.rec);
        check_flag({name, " pc_offset"}, r.offset, pc_offset);
        check_flag({name, " pc_overload"}, !r.offset, pc_overload);
        check_word({name, " target"}, r.value, r.offset ? pc_offset_value : pc_overload_value);
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (!reset) begin
            if (out_valid) begin
                check_bundle();
                owed_credits++;
                if (owed_credits > credits) begin
                    protocol_errors++;
                    $display("more bundles outstanding than there are credits");
                end
            end
            if (pc_offset || pc_overload) check_redirect();
        end
    end

    initial begin : credit_returner
        int unsigned delay;
        void'($urandom(32'h246c));
        forever begin
            @(posedge clk);
            if (owed_credits > 0) begin
                delay = $urandom_range(5, 0);
                repeat (delay) @(posedge clk);
                credit_return <= 1'b1;
                @(posedge clk);
                credit_return <= 1'b0;         // one-cycle pulse, consumed at this edge
                owed_credits--;
            end
        end
    end

    initial begin : watchdog
        wait (records_loaded);
        #(record_lines.size() * 7 * period + reset_cycles * period);
        $display("timeout: the run did not drain before the time limit");
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin : stimulus
        int total;
        in_valid       = 1'b0;
        in_instruction = '0;
        in_pc          = '0;
        credit_return  = 1'b0;
        wb_enable      = 1'b0;
        wb_idx         = '0;
        wb_data        = '0;
        load_records();
        records_loaded = 1'b1;
        do @(posedge clk); while (reset);
        foreach (record_lines[n]) run_record(n, record_lines[n]);
        in_valid  <= 1'b0;
        wb_enable <= 1'b0;
        while (bundle_q.size() != 0 || redirect_q.size() != 0 || owed_credits != 0) begin
            @(posedge clk);
        end
        repeat (8) @(posedge clk);             // room for a stray bundle to show up
        total = value_errors + protocol_errors + UUT.u_chk.assert_failures;
        $display("errors: %0d value, %0d protocol, %0d assertion", value_errors,
                 protocol_errors, UUT.u_chk.assert_failures);
        if (total == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== test/decode_stage_testdata.txt ====
# W idx data | I instr pc gap op1 op2 store_data rs_idx rt_idx dest alu mem_read mem_write
# R kind target (kind 1 = pc_offset, 2 = pc_overload), all hex, gap 1 = squashed slot
W 08 00000011
W 09 fffffffc
W 0a 00000011
W 1f 00400100
W 00 deadbeef
I 01091820 00400000 0 00000011 fffffffc fffffffc 08 09 03 0 0 0
I 010a2824 00400004 0 00000011 00000011 00000011 08 0a 05 2 0 0
I 2126fffe 00400008 0 fffffffc fffffffe 00000000 09 00 06 0 0 0
I 35278001 0040000c 0 fffffffc 00008001 00000000 09 00 07 3 0 0
I 3c0b1234 00400010 0 00000000 12340000 00000000 00 00 0b a 0 0
I 000860c0 00400014 0 00000003 00000011 00000011 00 08 0c 7 0 0
I 8d0d0008 00400018 0 00000011 00000008 00000000 08 00 0d 0 1 0
I ad0afffc 0040001c 0 00000011 fffffffc 00000011 08 0a 00 0 0 1
I 00007020 00400020 0 00000000 00000000 00000000 00 00 0e 0 0 0
I 02087825 00400024 0 0000abcd 00000011 00000011 10 08 0f 3 0 0
W 10 0000abcd
I 110a0003 00400028 0 00000011 0000000c 00000011 08 0a 00 1 0 0
R 1 0000000c
I 01091820 0040002c 1 0 0 0 0 0 0 0 0 0
I 150affff 00400034 0 00000011 fffffffc 00000011 08 0a 00 1 0 0
I 19200010 00400038 0 fffffffc 00000040 00000000 09 00 00 1 0 0
R 1 00000040
I 01091820 0040003c 1 0 0 0 0 0 0 0 0 0
I 1d00fff8 00400040 0 00000011 ffffffe0 00000000 08 00 00 1 0 0
R 1 ffffffe0
I 01091820 00400044 1 0 0 0 0 0 0 0 0 0
I 08100040 00400050 0 00000000 0000abcd 0000abcd 00 00 00 0 0 0
R 2 00400100
I 01091820 00400054 1 0 0 0 0 0 0 0 0 0
I 0c100080 30400060 0 30400060 00000004 0000abcd 00 00 1f 0 0 0
R 2 30400200
I 01091820 30400064 1 0 0 0 0 0 0 0 0 0
I 03e00008 00400070 0 00400100 00000000 00000000 1f 00 00 0 0 0
R 2 00400100
I 01091820 00400074 1 0 0 0 0 0 0 0 0 0
I 3911ff00 00400100 0 00000011 0000ff00 00000000 08 00 11 4 0 0

// ==== decode_stage.f ====
verilog/mips_pkg.sv
verilog/operand_if.sv
verilog/if_id_reg.sv
verilog/control_unit.sv
verilog/general_reg.sv
verilog/condition_check.sv
verilog/signal_mux.sv
verilog/id_ex_reg.sv
verilog/decode_stage.sv
test/tb_clock.sv
test/decode_stage_chk.sv
test/decode_stage_tb.sv
